//--- hdl/fetch_fsm.sv
`timescale 1ns/1ps
`include "prefetch_params.svh"

module fetch_fsm import prefetch_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       req_i,
  input  branch_t    branch_i,
  input  mem_rsp_t   mem_rsp_i,
  input  logic       space_avail_i,
  input  logic       out_valid_i,
  output mem_req_t   mem_req_o,
  output logic       rsp_keep_o,
  output logic       flush_o,
  output logic       fetch_failed_o,
  output logic       busy_o
);

  localparam int ADDR_W = `PF_ADDR_W;
  // number of low address bits that are always zero on the port
  localparam int LSB_W  = $clog2(`PF_INSTR_BYTES);

  fetch_state_e      state_q;
  fetch_state_e      state_d;
  logic [ADDR_W-1:0] addr_q;
  logic [ADDR_W-1:0] fetch_addr;
  logic [ADDR_W-1:0] branch_addr;
  logic              addr_valid;
  logic              issue;

  // clear the byte offset so only whole words are fetched
  function automatic logic [ADDR_W-1:0] word_align(input logic [ADDR_W-1:0] a);
    word_align = {a[ADDR_W-1:LSB_W], {LSB_W{1'b0}}};
  endfunction

  ////////////////////////////////////////////////////////////
  // address generation
  ////////////////////////////////////////////////////////////

  // next sequential word after the last address that was issued
  assign fetch_addr  = word_align(addr_q) + ADDR_W'(`PF_INSTR_BYTES);
  assign branch_addr = word_align(branch_i.addr);

  // every redirect empties the buffer stage in the same cycle
  assign flush_o = branch_i.valid;

  // the fsm counts as busy while anything is pending or being asked for
  assign busy_o = (state_q != IDLE) || mem_req_o.req;

  ////////////////////////////////////////////////////////////
  // request state machine
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    issue          = 1'b0;
    addr_valid     = 1'b0;
    rsp_keep_o     = 1'b0;
    fetch_failed_o = 1'b0;
    mem_req_o.req  = 1'b0;

    // a branch target always wins the address mux
    // otherwise a held request or a pending target keeps addr_q
    if (branch_i.valid) begin
      mem_req_o.addr = branch_addr;
    end else if (state_q == WAIT_GNT || state_q == WAIT_ABORTED) begin
      mem_req_o.addr = addr_q;
    end else begin
      mem_req_o.addr = fetch_addr;
    end

    case (state_q)
      // nothing outstanding, start as soon as there is room or a redirect
      IDLE: begin
        issue = req_i & (space_avail_i | branch_i.valid);
      end

      // the request stays up until the memory takes it
      WAIT_GNT: begin
        issue = 1'b1;
      end

      // one granted request is out and its response is due
      WAIT_RVALID: begin
        if (mem_rsp_i.rvalid) begin
          // a response landing together with a branch is already stale
          rsp_keep_o = ~branch_i.valid;
          issue      = req_i & (space_avail_i | branch_i.valid);
          if (!issue) begin
            state_d = IDLE;
          end
        end else if (branch_i.valid) begin
          // the old response is still on its way, so only remember the target
          addr_valid = 1'b1;
          state_d    = WAIT_ABORTED;
        end
      end

      // drop the stale response, then fetch the saved target
      WAIT_ABORTED: begin
        if (mem_rsp_i.rvalid) begin
          issue = 1'b1;
        end else if (branch_i.valid) begin
          // a second redirect just replaces the saved target
          addr_valid = 1'b1;
        end
      end

      // fetching stopped on a protection fault, only a branch restarts it
      WAIT_JUMP: begin
        fetch_failed_o = ~out_valid_i & ~branch_i.valid;
        issue          = branch_i.valid;
      end

      default: begin
        state_d = IDLE;
      end
    endcase

    // common issue path shared by all states
    // a faulting address is never put on the bus
    if (issue) begin
      if (mem_rsp_i.err_pmp) begin
        state_d = WAIT_JUMP;
      end else begin
        mem_req_o.req = 1'b1;
        addr_valid    = 1'b1;
        state_d       = mem_rsp_i.gnt ? WAIT_RVALID : WAIT_GNT;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // state and address registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      // addr_q follows whatever address was last driven with intent
      if (addr_valid) begin
        addr_q <= mem_req_o.addr;
      end
    end
  end

endmodule

//--- hdl/instr_buffer.sv
`timescale 1ns/1ps
`include "prefetch_params.svh"

module instr_buffer import prefetch_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  mem_rsp_t   mem_rsp_i,
  input  logic       rsp_keep_i,
  input  logic       flush_i,
  input  logic       ready_i,
  output instr_out_t instr_o,
  output logic       space_avail_o
);

  localparam int DEPTH  = `PF_FIFO_DEPTH;
  localparam int DATA_W = `PF_DATA_W;
  localparam int PTR_W  = $clog2(DEPTH);
  // usage needs one more code than the pointers to tell full from empty
  localparam int CNT_W  = $clog2(DEPTH + 1);

  logic [DATA_W-1:0] fifo_mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  usage;
  logic              fifo_empty;
  logic              push;
  logic              pop;

  // step a pointer around the ring, also for depths that are not a power of 2
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    ptr_next = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////
  // FIFO control
  ////////////////////////////////////////////////////////////

  assign fifo_empty = (usage == '0);

  // keep FIFO order, so a response only bypasses when nothing is queued
  assign push = rsp_keep_i & (~fifo_empty | ~ready_i);
  assign pop  = ~fifo_empty & ready_i & ~flush_i;

  // one slot stays free for the response that may still be in flight
  assign space_avail_o = (usage < CNT_W'(DEPTH - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      usage  <= '0;
    end else if (flush_i) begin
      // flush beats a push in the same cycle
      wr_ptr <= '0;
      rd_ptr <= '0;
      usage  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({push, pop})
        2'b10:   usage <= usage + 1'b1;
        2'b01:   usage <= usage - 1'b1;
        default: usage <= usage;
      endcase
    end
  end

  // payload storage
  always_ff @(posedge clk) begin
    if (push && !flush_i) begin
      fifo_mem[wr_ptr] <= mem_rsp_i.rdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // output select
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (!fifo_empty) begin
      instr_o.valid = 1'b1;
      instr_o.rdata = fifo_mem[rd_ptr];
    end else begin
      // empty FIFO, hand the live response straight to the core
      instr_o.valid = rsp_keep_i;
      instr_o.rdata = mem_rsp_i.rdata;
    end
    // nothing reaches the core in a redirect cycle
    if (flush_i) begin
      instr_o.valid = 1'b0;
    end
  end

endmodule

//--- hdl/prefetch_buffer.sv
`timescale 1ns/1ps
`include "prefetch_params.svh"

module prefetch_buffer import prefetch_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_i,
  input  logic                  branch_i,
  input  logic [`PF_ADDR_W-1:0] addr_i,
  input  logic                  ready_i,
  input  logic                  instr_gnt_i,
  input  logic [`PF_DATA_W-1:0] instr_rdata_i,
  input  logic                  instr_rvalid_i,
  input  logic                  instr_err_pmp_i,
  output logic                  valid_o,
  output logic [`PF_DATA_W-1:0] rdata_o,
  output logic                  instr_req_o,
  output logic [`PF_ADDR_W-1:0] instr_addr_o,
  output logic                  fetch_failed_o,
  output logic                  busy_o
);

  mem_req_t   mem_req;
  mem_rsp_t   mem_rsp;
  branch_t    branch;
  instr_out_t instr_out;
  logic       rsp_keep;
  logic       flush;
  logic       space_avail;

  ////////////////////////////////////////////////////////////
  // port packing
  ////////////////////////////////////////////////////////////

  assign branch.valid    = branch_i;
  assign branch.addr     = addr_i;
  assign mem_rsp.gnt     = instr_gnt_i;
  assign mem_rsp.rvalid  = instr_rvalid_i;
  assign mem_rsp.err_pmp = instr_err_pmp_i;
  assign mem_rsp.rdata   = instr_rdata_i;

  assign instr_req_o  = mem_req.req;
  assign instr_addr_o = mem_req.addr;
  assign valid_o      = instr_out.valid;
  assign rdata_o      = instr_out.rdata;

  // fetch stage talks to memory, buffer stage talks to the core
  fetch_fsm u_fetch_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch),
    .mem_rsp_i      (mem_rsp),
    .space_avail_i  (space_avail),
    .out_valid_i    (instr_out.valid),
    .mem_req_o      (mem_req),
    .rsp_keep_o     (rsp_keep),
    .flush_o        (flush),
    .fetch_failed_o (fetch_failed_o),
    .busy_o         (busy_o)
  );

  instr_buffer u_instr_buffer (
    .clk           (clk),
    .rst_n         (rst_n),
    .mem_rsp_i     (mem_rsp),
    .rsp_keep_i    (rsp_keep),
    .flush_i       (flush),
    .ready_i       (ready_i),
    .instr_o       (instr_out),
    .space_avail_o (space_avail)
  );

endmodule

//--- hdl/prefetch_params.svh
`ifndef PREFETCH_PARAMS_SVH
`define PREFETCH_PARAMS_SVH

////////////////////////////////////////////////////////////
// fetch port widths
////////////////////////////////////////////////////////////

// byte address of an instruction on the fetch port
`define PF_ADDR_W 32
// one instruction word as returned by the memory
`define PF_DATA_W 32

////////////////////////////////////////////////////////////
// buffering and sequencing
////////////////////////////////////////////////////////////

// entries in the instruction FIFO, never below 2
`define PF_FIFO_DEPTH 2
// address step between sequential words, also sets the cleared low bits
`define PF_INSTR_BYTES 4

`endif

//--- hdl/prefetch_pkg.sv
`include "prefetch_params.svh"

package prefetch_pkg;

  ////////////////////////////////////////////////////////////
  // fetch stage state machine
  ////////////////////////////////////////////////////////////

  // WAIT_ABORTED covers a response that is still due after a redirect
  // WAIT_JUMP is left only by a branch once a protection fault was seen
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    WAIT_ABORTED,
    WAIT_JUMP
  } fetch_state_e;

  ////////////////////////////////////////////////////////////
  // bundles on the memory and core sides
  ////////////////////////////////////////////////////////////

  // request towards instruction memory, addr is held until the grant
  typedef struct packed {
    logic                  req;
    logic [`PF_ADDR_W-1:0] addr;
  } mem_req_t;

  // everything the memory sends back, err_pmp judges the driven address
  typedef struct packed {
    logic                  gnt;
    logic                  rvalid;
    logic                  err_pmp;
    logic [`PF_DATA_W-1:0] rdata;
  } mem_rsp_t;

  // redirect strobe from the core together with its target
  typedef struct packed {
    logic                  valid;
    logic [`PF_ADDR_W-1:0] addr;
  } branch_t;

  // instruction offered to the fetch stage of the core
  typedef struct packed {
    logic                  valid;
    logic [`PF_DATA_W-1:0] rdata;
  } instr_out_t;

endpackage

//--- prefetch_buffer.f
+incdir+hdl
hdl/prefetch_pkg.sv
hdl/fetch_fsm.sv
hdl/instr_buffer.sv
hdl/prefetch_buffer.sv
tb/instr_mem_model.sv
tb/tb_prefetch_buffer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and searches the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_prefetch_buffer \
  -f prefetch_buffer.f -o sim_prefetch_buffer \
  && ./obj_dir/sim_prefetch_buffer > sim.log 2>&1
cat sim.log 2> /dev/null
grep -qx "PASS: all tests" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- tb/instr_mem_model.sv
`timescale 1ns/1ps
`include "prefetch_params.svh"

module instr_mem_model #(
  parameter int SEED = 32'h13bd43f0
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_i,
  input  logic [`PF_ADDR_W-1:0] addr_i,
  input  logic [`PF_ADDR_W-1:0] win_lo_i,
  input  logic [`PF_ADDR_W-1:0] win_hi_i,
  output logic                  gnt_o,
  output logic                  rvalid_o,
  output logic [`PF_DATA_W-1:0] rdata_o,
  output logic                  err_pmp_o
);

  integer                seed;
  int                    gnt_wait;
  int                    rsp_wait;
  logic                  pending;
  logic [`PF_ADDR_W-1:0] pend_addr;
  logic                  fire;
  logic                  req_seen;
  logic [`PF_ADDR_W-1:0] addr_seen;

  function automatic int delay_0_3();
    int r;
    r = $random(seed);
    delay_0_3 = r & 3;
  endfunction

  // the protection verdict follows the driven address with no delay
  assign err_pmp_o = (addr_i >= win_lo_i) && (addr_i < win_hi_i);

  // only one granted request may be out, a new grant is allowed in the rvalid cycle
  assign gnt_o = req_i && (gnt_wait == 0) && (!pending || rvalid_o);

  initial begin
    seed      = SEED;
    gnt_wait  = 0;
    rsp_wait  = 0;
    pending   = 1'b0;
    pend_addr = '0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    forever begin
      // look at the bus while it is stable, act just after the next rising edge
      @(negedge clk);
      fire      = gnt_o;
      req_seen  = req_i;
      addr_seen = addr_i;
      @(posedge clk);
      #1;
      if (!rst_n) begin
        pending  = 1'b0;
        rvalid_o = 1'b0;
      end else begin
        if (rvalid_o) begin
          pending = 1'b0;
        end
        if (fire) begin
          pending   = 1'b1;
          pend_addr = addr_seen;
          rsp_wait  = delay_0_3();
          gnt_wait  = delay_0_3();
        end else if (req_seen && gnt_wait > 0) begin
          gnt_wait--;
        end
        // idle data is garbage so that a wrongly latched word shows up
        rvalid_o = 1'b0;
        rdata_o  = $random(seed);
        if (pending) begin
          if (rsp_wait == 0) begin
            rvalid_o = 1'b1;
            rdata_o  = ~pend_addr;
          end else begin
            rsp_wait--;
          end
        end
      end
    end
  end

endmodule

//--- tb/tb_prefetch_buffer.sv
`timescale 1ns/1ps
`include "prefetch_params.svh"

module tb_prefetch_buffer;

  localparam int SEED_INIT   = 32'h13bd43f0;
  // cycle budget of each test
  // the run is cut off at four times their sum
  localparam int LEN_RESET   = 4;
  localparam int LEN_SEQ     = 400;
  localparam int LEN_BRANCH  = 400;
  localparam int LEN_BP      = 60;
  localparam int LEN_FAULT   = 100;
  localparam int LEN_IDLE    = 40;
  localparam int CYCLE_LIMIT = 4 * (LEN_RESET + LEN_SEQ + LEN_BRANCH + LEN_BP + LEN_FAULT
                                    + LEN_IDLE);

  logic                  clk;
  logic                  rst_n;
  logic                  req_i;
  logic                  branch_i;
  logic [`PF_ADDR_W-1:0] addr_i;
  logic                  ready_i;
  logic                  instr_gnt;
  logic [`PF_DATA_W-1:0] instr_rdata;
  logic                  instr_rvalid;
  logic                  instr_err_pmp;
  logic                  valid_o;
  logic [`PF_DATA_W-1:0] rdata_o;
  logic                  instr_req_o;
  logic [`PF_ADDR_W-1:0] instr_addr_o;
  logic                  fetch_failed_o;
  logic                  busy_o;

  integer                seed;
  int                    cycles = 0;
  int                    errors;
  int                    checks;
  int                    tests;
  int                    err_base;
  // granted words of the live stream that the core has not taken yet
  int                    live;
  // model program counter of the next word the core should take
  logic [`PF_ADDR_W-1:0] pc;
  // address the next request on the memory port should carry
  logic [`PF_ADDR_W-1:0] next_req;
  logic [`PF_ADDR_W-1:0] win_lo;
  logic [`PF_ADDR_W-1:0] win_hi;
  logic                  br_pick;

  prefetch_buffer UUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (req_i),
    .branch_i        (branch_i),
    .addr_i          (addr_i),
    .ready_i         (ready_i),
    .instr_gnt_i     (instr_gnt),
    .instr_rdata_i   (instr_rdata),
    .instr_rvalid_i  (instr_rvalid),
    .instr_err_pmp_i (instr_err_pmp),
    .valid_o         (valid_o),
    .rdata_o         (rdata_o),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .fetch_failed_o  (fetch_failed_o),
    .busy_o          (busy_o)
  );

  instr_mem_model #(.SEED(SEED_INIT)) u_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_i     (instr_req_o),
    .addr_i    (instr_addr_o),
    .win_lo_i  (win_lo),
    .win_hi_i  (win_hi),
    .gnt_o     (instr_gnt),
    .rvalid_o  (instr_rvalid),
    .rdata_o   (instr_rdata),
    .err_pmp_o (instr_err_pmp)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // random helpers
  ////////////////////////////////////////////////////////////

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    rand_below = (r & 32'h7fff_ffff) % n;
  endfunction

  function automatic logic chance(input int pct);
    chance = (rand_below(100) < pct);
  endfunction

  // branch targets stay below the fault window
  // the two low bits stay random so that the word alignment is exercised
  function automatic logic [`PF_ADDR_W-1:0] rand_addr();
    rand_addr = $random(seed) & 32'h3fff_ffff;
  endfunction

  ////////////////////////////////////////////////////////////
  // checking and reporting
  ////////////////////////////////////////////////////////////

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error %s: got %h, expected %h at cycle %0d", name, got, exp, cycles);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%s at cycle %0d", what, cycles);
  endtask

  task automatic start_test();
    err_base = errors;
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - err_base);
  endtask

  // one clock of stimulus followed by the model and the checks at the falling edge
  task automatic run_cycle(input logic rdy, input logic rq, input logic br,
                           input logic [`PF_ADDR_W-1:0] tgt);
    logic                  fire;
    logic [`PF_ADDR_W-1:0] tgt_word;
    @(posedge clk);
    #1;
    ready_i  = rdy;
    req_i    = rq;
    branch_i = br;
    addr_i   = tgt;
    @(negedge clk);
    fire     = instr_req_o & instr_gnt;
    tgt_word = tgt & ~32'(`PF_INSTR_BYTES - 1);

    // a redirect restarts the request stream at the word of the target
    if (br) begin
      next_req = tgt_word;
    end
    // a held request keeps its address until the memory grants it
    if (instr_req_o) begin
      check_eq("instr_addr_o", instr_addr_o, next_req);
      if (fire) begin
        next_req = next_req + 32'(`PF_INSTR_BYTES);
      end
    end

    if (br) begin
      check_eq("valid_o", 32'(valid_o), 32'h0);
      pc   = tgt_word;
      live = fire ? 1 : 0;
    end else begin
      if (fire) begin
        live++;
      end
      if (valid_o && ready_i) begin
        check_eq("rdata_o", rdata_o, ~pc);
        if (pc >= win_lo && pc < win_hi) begin
          report_failure("a word from inside the fault window was delivered");
        end
        pc = pc + 32'(`PF_INSTR_BYTES);
        live--;
      end
    end
    if (live > `PF_FIFO_DEPTH) begin
      report_failure("more words are outstanding than the FIFO can hold");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed     = SEED_INIT;
    clk      = 1'b0;
    rst_n    = 1'b0;
    req_i    = 1'b0;
    branch_i = 1'b0;
    addr_i   = '0;
    ready_i  = 1'b0;
    errors   = 0;
    checks   = 0;
    tests    = 0;
    live     = 0;
    pc       = '0;
    next_req = '0;
    // the fault window sits in the upper half well away from the random targets
    win_lo   = 32'h8000_0000 | ($random(seed) & 32'h0fff_ff00);
    win_hi   = win_lo + 32'h40;

    start_test();
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    check_eq("instr_req_o", 32'(instr_req_o), 32'h0);
    check_eq("valid_o", 32'(valid_o), 32'h0);
    check_eq("fetch_failed_o", 32'(fetch_failed_o), 32'h0);
    check_eq("busy_o", 32'(busy_o), 32'h0);
    finish_test("reset");

    // a start address is needed before any sequential fetch makes sense
    start_test();
    run_cycle(1'b1, 1'b1, 1'b1, rand_addr());
    for (int i = 0; i < LEN_SEQ; i++) begin
      run_cycle(chance(60), ~chance(5), 1'b0, '0);
    end
    finish_test("sequential with stalls");

    // every branch comes with req_i high
    start_test();
    for (int i = 0; i < LEN_BRANCH; i++) begin
      br_pick = chance(6);
      run_cycle(chance(70), br_pick | ~chance(4), br_pick, rand_addr());
    end
    finish_test("branch redirect");

    // the core stops taking words until the fetch side has to give up
    start_test();
    for (int i = 0; i < 48; i++) begin
      run_cycle(1'b0, 1'b1, 1'b0, '0);
      if (i >= 32) begin
        check_eq("instr_req_o", 32'(instr_req_o), 32'h0);
      end
    end
    for (int i = 0; i < 10; i++) begin
      run_cycle(1'b1, 1'b1, 1'b0, '0);
    end
    finish_test("back-pressure");

    // run two words up to the window and then stay parked at its edge
    start_test();
    run_cycle(1'b1, 1'b1, 1'b1, win_lo - 32'h8);
    while (pc != win_lo) begin
      run_cycle(1'b1, 1'b1, 1'b0, '0);
    end
    while (!fetch_failed_o) begin
      run_cycle(1'b1, 1'b1, 1'b0, '0);
    end
    for (int i = 0; i < 8; i++) begin
      run_cycle(1'b1, 1'b1, 1'b0, '0);
      check_eq("fetch_failed_o", 32'(fetch_failed_o), 32'h1);
      check_eq("instr_req_o", 32'(instr_req_o), 32'h0);
      check_eq("valid_o", 32'(valid_o), 32'h0);
    end
    // a branch back below the window restarts delivery
    run_cycle(1'b1, 1'b1, 1'b1, rand_addr());
    check_eq("fetch_failed_o", 32'(fetch_failed_o), 32'h0);
    for (int i = 0; i < 40; i++) begin
      run_cycle(chance(70), 1'b1, 1'b0, '0);
      check_eq("fetch_failed_o", 32'(fetch_failed_o), 32'h0);
    end
    finish_test("protection fault");

    // drain whatever is still in flight once req_i has dropped
    start_test();
    run_cycle(1'b1, 1'b0, 1'b0, '0);
    while (busy_o || valid_o) begin
      run_cycle(1'b1, 1'b0, 1'b0, '0);
    end
    for (int i = 0; i < 12; i++) begin
      run_cycle(1'b1, 1'b0, 1'b0, '0);
      check_eq("instr_req_o", 32'(instr_req_o), 32'h0);
      check_eq("busy_o", 32'(busy_o), 32'h0);
    end
    finish_test("idle and busy");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
